/* vlog.f */
+incdir+source
source/wideSubPkg.sv
source/prefixAndOr.sv
source/subV.sv
source/limbStage.sv
source/diffFlags.sv
source/wideSub.sv
dv/clkGen.sv
dv/wideSubTb.sv

/* run.sh */
#!/bin/sh
# compile and run the wideSub testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/10ps \
	-f vlog.f --top-module wideSubTb --Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

simOut=$(./obj_dir/VwideSubTb 2>&1)
simStatus=$?
echo "$simOut"
if [ $simStatus -ne 0 ]; then
	echo "simulation exited with status $simStatus"
	exit 1
fi

if echo "$simOut" | grep -qx "Test OK"; then
	exit 0
fi
echo "pass line missing from simulation output"
exit 1

/* dv/wideSubTb.sv */
`timescale 1ns/10ps

// testbench for the pipelined subtractor
module wideSubTb;

	localparam int latency = 5;      // four limb stages plus the flag stage
	localparam int maxCycles = 800;  // 16 reset + ~40 directed + ~375 random + drain, with margin
	localparam longint maxS = 64'sd2147483647;
	localparam longint minS = -maxS - 1;

	logic clk;
	logic arstN;
	logic validIn;
	wideSubPkg::wordT a;
	wideSubPkg::wordT b;
	logic ci;
	logic sat;
	logic validOut;
	wideSubPkg::wordT diff;
	logic zero;
	logic neg;
	logic ovf;

	integer seed;
	int inCnt;          // items driven
	int outCnt;         // items seen on validOut
	int cycleCnt;
	logic [latency-1:0] hValid; // input history, index latency-1 is oldest
	logic [latency-1:0] hCi;
	logic [latency-1:0] hSat;
	wideSubPkg::wordT hA [latency];
	wideSubPkg::wordT hB [latency];
	logic expValid;
	logic expOvf;
	wideSubPkg::wordT expDiff;

	clkGen clk_i (
		.clk(clk),
		.arstN(arstN)
	);

	wideSub dut_i (
		.clk(clk),
		.arstN(arstN),
		.validIn(validIn),
		.a(a),
		.b(b),
		.ci(ci),
		.sat(sat),
		.validOut(validOut),
		.diff(diff),
		.zero(zero),
		.neg(neg),
		.ovf(ovf)
	);

	// exact signed a - b - ci, wide enough to never wrap
	function automatic longint exactDiff(input wideSubPkg::wordT x, input wideSubPkg::wordT y,
		input logic c);
		return longint'(signed'(x)) - longint'(signed'(y)) - longint'(c);
	endfunction

	function automatic logic modelOvf(input wideSubPkg::wordT x, input wideSubPkg::wordT y,
		input logic c);
		longint e;
		e = exactDiff(x, y, c);
		return (e > maxS) || (e < minS);
	endfunction

	function automatic wideSubPkg::wordT modelDiff(input wideSubPkg::wordT x,
		input wideSubPkg::wordT y, input logic c, input logic s);
		wideSubPkg::wordT raw;
		raw = wideSubPkg::wordT'(exactDiff(x, y, c)); // modulo 2^32
		if (s && modelOvf(x, y, c)) begin
			raw = x[31] ? 32'h80000000 : 32'h7FFFFFFF; // clamp side follows sign of a
		end
		return raw;
	endfunction

	task automatic stopRun(input string why);
		$display("%s", why);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic reportMismatch(input string what, input wideSubPkg::wordT expV,
		input wideSubPkg::wordT obsV);
		stopRun($sformatf("Mismatch at %0t: %s expected %h observed %h", $time, what, expV, obsV));
	endtask

	task automatic sendItem(input wideSubPkg::wordT aV, input wideSubPkg::wordT bV,
		input logic ciV, input logic satV);
		@(negedge clk);
		validIn = 1'b1;
		a = aV;
		b = bV;
		ci = ciV;
		sat = satV;
		inCnt++;
	endtask

	task automatic idleCycle();
		@(negedge clk);
		validIn = 1'b0;
		a = $random(seed); // junk data must not leak out
		b = $random(seed);
	endtask

	always @(posedge clk) begin
		hValid <= {hValid[latency-2:0], validIn};
		hCi <= {hCi[latency-2:0], ci};
		hSat <= {hSat[latency-2:0], sat};
		hA[0] <= a;
		hB[0] <= b;
		for (int i = 1; i < latency; i++) begin
			hA[i] <= hA[i-1];
			hB[i] <= hB[i-1];
		end
	end

	assign expValid = hValid[latency-1];
	assign expOvf = modelOvf(hA[latency-1], hB[latency-1], hCi[latency-1]);
	assign expDiff = modelDiff(hA[latency-1], hB[latency-1], hCi[latency-1], hSat[latency-1]);

	resetQuiet: assert property (@(posedge clk) !arstN |-> !validOut)
		else stopRun("validOut was high during reset");
	validTrack: assert property (@(posedge clk) disable iff (!arstN) validOut == expValid)
		else reportMismatch("validOut", 32'($sampled(expValid)), 32'($sampled(validOut)));
	diffCheck: assert property (@(posedge clk) disable iff (!arstN) validOut |-> diff == expDiff)
		else reportMismatch("diff", $sampled(expDiff), $sampled(diff));
	ovfCheck: assert property (@(posedge clk) disable iff (!arstN) validOut |-> ovf == expOvf)
		else reportMismatch("ovf", 32'($sampled(expOvf)), 32'($sampled(ovf)));
	zeroCheck: assert property (@(posedge clk) disable iff (!arstN)
		validOut |-> zero == (expDiff == '0))
		else reportMismatch("zero", 32'($sampled(expDiff) == '0), 32'($sampled(zero)));
	negCheck: assert property (@(posedge clk) disable iff (!arstN) validOut |-> neg == expDiff[31])
		else reportMismatch("neg", 32'($sampled(expDiff[31])), 32'($sampled(neg)));

	always @(posedge clk) begin
		cycleCnt++;
		if (arstN && validOut) begin
			outCnt++;
		end
		if (cycleCnt >= maxCycles) begin
			stopRun("timeout, the run did not finish within the cycle limit");
		end
	end

	initial begin
		wideSubPkg::wordT r;
		seed = 85;
		inCnt = 0;
		outCnt = 0;
		cycleCnt = 0;
		validIn = 1'b0;
		a = '0;
		b = '0;
		ci = 1'b0;
		sat = 1'b0;
		wait (arstN === 1'b1);

		sendItem(0, 1, 1'b0, 1'b0);                       // borrow through every limb
		sendItem(32'h01000000, 1, 1'b0, 1'b0);
		sendItem(32'h00010000, 1, 1'b0, 1'b0);
		sendItem(32'h12345678, 32'h12345678, 1'b1, 1'b0); // a = b with ci
		sendItem(32'h12345678, 32'h12345678, 1'b0, 1'b0); // zero
		sendItem(32'h80000000, 1, 1'b0, 1'b0);            // wraps positive
		sendItem(32'h80000000, 1, 1'b0, 1'b1);
		sendItem(32'h7FFFFFFF, 32'hFFFFFFFF, 1'b0, 1'b0);
		sendItem(32'h7FFFFFFF, 32'hFFFFFFFF, 1'b0, 1'b1);
		sendItem(32'h80000000, 0, 1'b1, 1'b1);            // ci alone overflows
		sendItem(32'h7FFFFFFF, 32'h80000000, 1'b0, 1'b1);
		sendItem(0, 32'h80000000, 1'b0, 1'b1);
		sendItem(32'hFFFFFFFF, 32'h7FFFFFFF, 1'b1, 1'b1);
		sendItem(5, 3, 1'b0, 1'b1);                       // sat on, no overflow
		sendItem(7, 7, 1'b0, 1'b1);
		sendItem(3, 5, 1'b0, 1'b1);
		sendItem(0, 0, 1'b1, 1'b1);
		sendItem(32'h80000000, 32'h80000000, 1'b0, 1'b1);
		sendItem(32'h00FF00FF, 32'h01000100, 1'b0, 1'b0);
		idleCycle();
		idleCycle();
		sendItem(32'hFFFFFFFF, 0, 1'b1, 1'b0);
		sendItem(32'h40000000, 32'hC0000000, 1'b0, 1'b0);
		sendItem(32'hC0000000, 32'h40000001, 1'b0, 1'b1);
		idleCycle();
		for (int k = 0; k < 16; k++) begin
			sendItem(32'h1 << (2 * k), 32'h1, k[0], k[1]); // single borrow walking up
		end

		for (int i = 0; i < 300; i++) begin
			if (($random(seed) & 3) == 0) begin
				idleCycle();
			end
			r = $random(seed);
			sendItem($random(seed), $random(seed), r[0], r[1]);
		end
		idleCycle();

		wait (outCnt == inCnt);
		repeat (latency) @(negedge clk);
		if (outCnt == inCnt) begin
			$display("Test OK");
			$finish;
		end else begin
			stopRun("more items left the pipeline than entered it");
		end
	end

endmodule

/* dv/clkGen.sv */
`timescale 1ns/10ps

// free running clock and power-on reset
module clkGen #(
	parameter int halfPeriod = 10,  // ns, gives a 20 ns period
	parameter int resetCycles = 16
) (
	output logic clk,
	output logic arstN
);

	initial begin
		clk = 1'b0;
		forever #(halfPeriod) clk = ~clk;
	end

	initial begin
		arstN = 1'b0;
		repeat (resetCycles) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1; // released away from the rising edge
	end

endmodule

/* source/wideSub.sv */
`timescale 1ns/10ps
`include "wideSub_config.svh"

// pipelined a - b - ci, one limb per stage then a flag stage
module wideSub (
	input  logic              clk,
	input  logic              arstN,
	input  logic              validIn,
	input  wideSubPkg::wordT  a,
	input  wideSubPkg::wordT  b,
	input  logic              ci,  // extra one subtracted
	input  logic              sat, // clamp on signed overflow
	output logic              validOut,
	output wideSubPkg::wordT  diff,
	output logic              zero,
	output logic              neg,
	output logic              ovf
);

	localparam int limbN = `WIDE_SUB_LIMB_N;

	// index k feeds stage k, index limbN feeds the flag stage
	logic [limbN:0]   validC;
	logic [limbN:0]   borrowC;
	logic [limbN:0]   satC;
	logic [limbN-1:0] ovfC;    // per-stage limb overflow
	wideSubPkg::wordT aC [limbN+1];
	wideSubPkg::wordT bC [limbN+1];
	wideSubPkg::wordT diffC [limbN+1];

	assign validC[0] = validIn;
	assign borrowC[0] = ci;    // carry in enters as the first borrow
	assign satC[0] = sat;
	assign aC[0] = a;
	assign bC[0] = b;
	assign diffC[0] = '0;      // nothing final yet

	for (genvar k = 0; k < limbN; k++) begin : stageG
		limbStage #(
			.limbIdx(k)
		) stage_i (
			.clk(clk),
			.arstN(arstN),
			.validIn(validC[k]),
			.aIn(aC[k]),
			.bIn(bC[k]),
			.diffIn(diffC[k]),
			.borrowIn(borrowC[k]),
			.satIn(satC[k]),
			.validOut(validC[k+1]),
			.aOut(aC[k+1]),
			.bOut(bC[k+1]),
			.diffOut(diffC[k+1]),
			.borrowOut(borrowC[k+1]),
			.satOut(satC[k+1]),
			.ovfOut(ovfC[k])
		);
	end

	diffFlags flags_i (
		.clk(clk),
		.arstN(arstN),
		.validIn(validC[limbN]),
		.aIn(aC[limbN]),
		.diffIn(diffC[limbN]),
		.satIn(satC[limbN]),
		.ovfIn(ovfC[limbN-1]), // top limb decides signed overflow
		.validOut(validOut),
		.diff(diff),
		.zero(zero),
		.neg(neg),
		.ovf(ovf)
	);

endmodule

/* source/diffFlags.sv */
`timescale 1ns/10ps

// final stage that clamps on overflow and registers result and flags
module diffFlags (
	input  logic              clk,
	input  logic              arstN,
	input  logic              validIn,
	input  wideSubPkg::wordT  aIn,    // sign of a picks the clamp limit
	input  wideSubPkg::wordT  diffIn, // raw difference
	input  logic              satIn,
	input  logic              ovfIn,  // overflow of the top limb
	output logic              validOut,
	output wideSubPkg::wordT  diff,
	output logic              zero,
	output logic              neg,
	output logic              ovf
);

	localparam int wordW = $bits(wideSubPkg::wordT);

	wideSubPkg::wordT maxPos; // largest signed value
	wideSubPkg::wordT minNeg; // smallest signed value
	wideSubPkg::wordT satVal;

	assign maxPos = {1'b0, {(wordW-1){1'b1}}};
	assign minNeg = ~maxPos;

	always_comb begin
		satVal = diffIn;
		if (satIn && ovfIn) begin
			satVal = aIn[wordW-1] ? minNeg : maxPos; // a negative can only underflow
		end
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validOut <= 1'b0;
			diff <= '0;
			zero <= 1'b0;
			neg <= 1'b0;
			ovf <= 1'b0;
		end else begin
			validOut <= validIn;
			diff <= satVal;
			zero <= (satVal == '0); // flags follow the clamped value
			neg <= satVal[wordW-1];
			ovf <= ovfIn;           // reported even when clamped
		end
	end

	// an overflowing raw difference has the sign opposite to a
	ovfFlipsSign: assert property (@(posedge clk) disable iff (!arstN)
		validIn && ovfIn |-> diffIn[wordW-1] != aIn[wordW-1])
		else $error("overflow flagged without a sign flip of the raw difference");

endmodule

/* source/limbStage.sv */
`timescale 1ns/10ps
`include "wideSub_config.svh"

// one pipeline stage, subtracts limb limbIdx and hands the rest on
module limbStage #(
	parameter int limbIdx = 0 // limb handled by this stage
) (
	input  logic              clk,
	input  logic              arstN,
	input  logic              validIn,
	input  wideSubPkg::wordT  aIn,       // full minuend
	input  wideSubPkg::wordT  bIn,       // full subtrahend
	input  wideSubPkg::wordT  diffIn,    // limbs below limbIdx already final
	input  logic              borrowIn,  // from the limb below
	input  logic              satIn,
	output logic              validOut,
	output wideSubPkg::wordT  aOut,
	output wideSubPkg::wordT  bOut,
	output wideSubPkg::wordT  diffOut,   // now final up to limbIdx
	output logic              borrowOut,
	output logic              satOut,
	output logic              ovfOut     // signed overflow of this limb
);

	localparam int lo = limbIdx * `WIDE_SUB_LIMB_W; // lsb of the limb

	wideSubPkg::limbT limbA;
	wideSubPkg::limbT limbB;
	wideSubPkg::limbT limbS;
	logic             limbV;
	logic             limbBo;
	wideSubPkg::wordT diffNext; // partial difference with this limb merged

	assign limbA = aIn[lo +: `WIDE_SUB_LIMB_W];
	assign limbB = bIn[lo +: `WIDE_SUB_LIMB_W];

	subV #(
		.width(`WIDE_SUB_LIMB_W),
		.speed(`WIDE_SUB_PREFIX_SPEED)
	) sub_i (
		.a(limbA),
		.b(limbB),
		.ci(borrowIn),
		.s(limbS),
		.v(limbV),
		.bo(limbBo)
	);

	always_comb begin
		diffNext = diffIn;
		diffNext[lo +: `WIDE_SUB_LIMB_W] = limbS; // overwrite own limb only
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			validOut <= 1'b0;
			aOut <= '0;
			bOut <= '0;
			diffOut <= '0;
			borrowOut <= 1'b0;
			satOut <= 1'b0;
			ovfOut <= 1'b0;
		end else begin
			validOut <= validIn;
			aOut <= aIn;    // upper limbs still needed
			bOut <= bIn;
			diffOut <= diffNext;
			borrowOut <= limbBo;
			satOut <= satIn;
			ovfOut <= limbV; // only the top limb value matters
		end
	end

	// a valid item leaving the stage carries a known borrow and partial result
	validKnown: assert property (@(posedge clk) disable iff (!arstN)
		validOut |-> !$isunknown({borrowOut, diffOut}))
		else $error("limb stage %0d passes unknown borrow or difference", limbIdx);

endmodule

/* source/subV.sv */
`timescale 1ns/10ps

// s = a - b - ci on width bits with signed overflow and borrow out
module subV #(
	parameter int width = 8, // word width
	parameter int speed = 1  // prefix tree select
) (
	input  logic [width-1:0] a,  // minuend
	input  logic [width-1:0] b,  // subtrahend
	input  logic             ci, // borrow in, subtracted
	output logic [width-1:0] s,  // difference
	output logic             v,  // two's complement overflow
	output logic             bo  // borrow out for the next limb
);

	logic [width-1:0] bInv;  // a + ~b + ~ci form
	logic             ciInv; // carry in of the adder
	logic [width-1:0] pt;    // half sum per bit
	logic [width-1:0] gi;
	logic [width-1:0] pi;
	logic [width-1:0] go;    // carry out of each bit

	assign bInv = ~b;
	assign ciInv = ~ci;
	assign pt = a ^ bInv;

	// bit 0 absorbs the carry in, so its propagate is never needed
	assign gi[0] = (a[0] & bInv[0]) | (a[0] & ciInv) | (bInv[0] & ciInv);
	assign pi[0] = 1'b0;
	assign gi[width-1:1] = a[width-1:1] & bInv[width-1:1];
	assign pi[width-1:1] = a[width-1:1] | bInv[width-1:1];

	prefixAndOr #(
		.width(width),
		.speed(speed)
	) prefix_i (
		.gi(gi),
		.pi(pi),
		.go(go),
		.po()  // group propagate not needed here
	);

	assign s = pt ^ {go[width-2:0], ciInv}; // carry into each bit
	assign v = go[width-1] ^ go[width-2];   // carry into msb differs from carry out
	assign bo = ~go[width-1];               // no carry out means a borrow

endmodule

/* source/prefixAndOr.sv */
`timescale 1ns/10ps

// parallel-prefix network for generate/propagate pairs
// every tree is built as a stack of levels where each bit either
// passes through (white node) or merges with a lower group (black node)
module prefixAndOr #(
	parameter int width = 8, // bits in the prefix
	parameter int speed = 1  // selects serial, brent-kung or sklansky tree
) (
	input  logic [width-1:0] gi, // bit generate
	input  logic [width-1:0] pi, // bit propagate
	output logic [width-1:0] go, // group generate down to bit 0
	output logic [width-1:0] po  // group propagate down to bit 0
);

	localparam int depth = $clog2(width); // log2 of the width, rounded up

	// number of node levels for the selected tree
	localparam int lvlN = (speed == 0) ? width - 1 :
		(speed == 2) ? depth : 2 * depth - 1;

	// lower node that bit i merges with at level lvl, or -1 to pass through
	function automatic int srcIdx(input int lvl, input int i);
		int span;
		int res;
		res = -1;
		if (speed == 0) begin
			// one bit per level, plain ripple
			if (i == lvl) begin
				res = i - 1;
			end
		end else if (speed == 2) begin
			span = 1 << (lvl - 1); // half block
			if ((i / span) % 2 == 1) begin
				res = (i / (2 * span)) * (2 * span) + span - 1; // top of lower half
			end
		end else begin
			if (lvl <= depth) begin
				// up-sweep builds power-of-two groups
				span = 1 << lvl;
				if ((i + 1) % span == 0) begin
					res = i - span / 2;
				end
			end else begin
				// down-sweep fills the bits between the groups
				span = 1 << (2 * depth - lvl);
				if ((i + 1) % span == span / 2 && i >= span) begin
					res = i - span / 2;
				end
			end
		end
		return res;
	endfunction

	for (genvar l = 0; l <= lvlN; l++) begin : lvlG
		logic [width-1:0] g; // generate after this level
		logic [width-1:0] p; // propagate after this level

		if (l == 0) begin : leafG
			assign g = gi;
			assign p = pi;
		end else begin : nodeG
			for (genvar i = 0; i < width; i++) begin : bitG
				localparam int src = srcIdx(l, i);

				if (src >= 0) begin : blackG
					// upper group wins or passes the lower carry
					assign g[i] = lvlG[l-1].g[i] | (lvlG[l-1].p[i] & lvlG[l-1].g[src]);
					assign p[i] = lvlG[l-1].p[i] & lvlG[l-1].p[src];
				end else begin : whiteG
					assign g[i] = lvlG[l-1].g[i];
					assign p[i] = lvlG[l-1].p[i];
				end
			end
		end
	end

	assign go = lvlG[lvlN].g; // carry out of each bit
	assign po = lvlG[lvlN].p;

endmodule

/* source/wideSubPkg.sv */
`include "wideSub_config.svh"

package wideSubPkg;

	// one limb of an operand or of the limb difference
	typedef logic [`WIDE_SUB_LIMB_W-1:0] limbT;

	// full word built from all limbs
	typedef logic [`WIDE_SUB_LIMB_W*`WIDE_SUB_LIMB_N-1:0] wordT;

endpackage

/* source/wideSub_config.svh */
`ifndef WIDE_SUB_CONFIG_SVH
`define WIDE_SUB_CONFIG_SVH

// bits per limb
`define WIDE_SUB_LIMB_W 8

// limbs per word and number of limb stages
`define WIDE_SUB_LIMB_N 4

// prefix tree inside each limb subtractor (0 serial, 1 brent-kung, 2 sklansky)
`define WIDE_SUB_PREFIX_SPEED 1

`endif
